// File: rtl/cgra_pkg.sv
package cgra_pkg;

    localparam int data_w    = 32;
    localparam int inst_w    = 28;
    localparam int buf_depth = 16;
    localparam int buf_aw    = $clog2(buf_depth);  // counters wrap at buf_depth
    localparam int n_regs    = 4;

    // crossbar select fields: a, b, n, s, w, e
    localparam int sel_w    = 3;
    localparam int n_sel    = 6;
    localparam int switch_w = n_sel * sel_w;
    localparam int op_w     = 4;

    // instruction field positions
    localparam int inst_reg_sel_lsb = 0;
    localparam int inst_c1_bit      = 4;
    localparam int inst_c2_bit      = 5;
    localparam int inst_switch_lsb  = 6;
    localparam int inst_op_lsb      = 24;

    localparam logic [sel_w-1:0] src_zero = 3'd0;
    localparam logic [sel_w-1:0] src_in0  = 3'd1;
    localparam logic [sel_w-1:0] src_in1  = 3'd2;
    localparam logic [sel_w-1:0] src_r0   = 3'd3;
    localparam logic [sel_w-1:0] src_r1   = 3'd4;
    localparam logic [sel_w-1:0] src_r2   = 3'd5;
    localparam logic [sel_w-1:0] src_r3   = 3'd6;
    localparam logic [sel_w-1:0] src_res  = 3'd7;

    // fu opcodes, 9..15 give zero
    localparam logic [op_w-1:0] op_pass = 4'd0;
    localparam logic [op_w-1:0] op_add  = 4'd1;
    localparam logic [op_w-1:0] op_sub  = 4'd2;
    localparam logic [op_w-1:0] op_mul  = 4'd3;
    localparam logic [op_w-1:0] op_and  = 4'd4;
    localparam logic [op_w-1:0] op_or   = 4'd5;
    localparam logic [op_w-1:0] op_xor  = 4'd6;
    localparam logic [op_w-1:0] op_shl  = 4'd7;
    localparam logic [op_w-1:0] op_shr  = 4'd8;

endpackage

// File: rtl/pe_config_buffer.sv
`timescale 1ns/1ps

module pe_config_buffer
    import cgra_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              init,
    input  logic              run,
    input  logic [inst_w-1:0] inst_in,
    output logic [inst_w-1:0] inst
);

    logic [inst_w-1:0] slots [buf_depth];
    logic [buf_aw-1:0] init_count;  // next slot to load
    logic [buf_aw-1:0] run_count;   // next slot to issue

    // init wins over run
    always_ff @(posedge clk) begin
        if (rst) begin
            init_count <= '0;
            run_count  <= '0;
            inst       <= '0;
            for (int i = 0; i < buf_depth; i++) begin
                slots[i] <= '0;
            end
        end else if (init) begin
            slots[init_count] <= inst_in;
            init_count        <= init_count + 1'b1;
        end else if (run) begin
            inst      <= slots[run_count];
            run_count <= run_count + 1'b1;
        end
    end

endmodule

// File: rtl/pe_reg_file.sv
`timescale 1ns/1ps

module pe_reg_file
    import cgra_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [n_regs-1:0] reg_sel,
    input  logic [data_w-1:0] din_0,
    input  logic [data_w-1:0] din_1,
    input  logic [data_w-1:0] din_2,
    input  logic [data_w-1:0] din_3,
    input  logic [data_w-1:0] din_res,
    output logic [data_w-1:0] r0,
    output logic [data_w-1:0] r1,
    output logic [data_w-1:0] r2,
    output logic [data_w-1:0] r3
);

    logic [data_w-1:0] din  [n_regs];
    logic [data_w-1:0] regs [n_regs];

    assign din[0] = din_0;
    assign din[1] = din_1;
    assign din[2] = din_2;
    assign din[3] = din_3;

    // every register reloads each cycle, own input or the result
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < n_regs; k++) begin
                regs[k] <= '0;
            end
        end else begin
            for (int k = 0; k < n_regs; k++) begin
                regs[k] <= reg_sel[k] ? din[k] : din_res;
            end
        end
    end

    assign r0 = regs[0];
    assign r1 = regs[1];
    assign r2 = regs[2];
    assign r3 = regs[3];

endmodule

// File: rtl/pe_crossbar.sv
`timescale 1ns/1ps

module pe_crossbar
    import cgra_pkg::*;
(
    input  logic [switch_w-1:0] switch,
    input  logic [data_w-1:0]   in0,
    input  logic [data_w-1:0]   in1,
    input  logic [data_w-1:0]   r0,
    input  logic [data_w-1:0]   r1,
    input  logic [data_w-1:0]   r2,
    input  logic [data_w-1:0]   r3,
    input  logic [data_w-1:0]   res,
    output logic [data_w-1:0]   op_a,
    output logic [data_w-1:0]   op_b,
    output logic [data_w-1:0]   dout_n,
    output logic [data_w-1:0]   dout_s,
    output logic [data_w-1:0]   dout_w,
    output logic [data_w-1:0]   dout_e
);

    logic [data_w-1:0] srcs [2**sel_w];
    logic [data_w-1:0] outs [n_sel];

    // source table indexed by select code
    assign srcs[src_zero] = '0;
    assign srcs[src_in0]  = in0;
    assign srcs[src_in1]  = in1;
    assign srcs[src_r0]   = r0;
    assign srcs[src_r1]   = r1;
    assign srcs[src_r2]   = r2;
    assign srcs[src_r3]   = r3;
    assign srcs[src_res]  = res;

    // one 8:1 mux per switch field, lowest field first
    for (genvar k = 0; k < n_sel; k++) begin : g_sel
        assign outs[k] = srcs[switch[k*sel_w +: sel_w]];
    end

    assign op_a   = outs[0];
    assign op_b   = outs[1];
    assign dout_n = outs[2];
    assign dout_s = outs[3];
    assign dout_w = outs[4];
    assign dout_e = outs[5];

endmodule

// File: rtl/pe_fu.sv
`timescale 1ns/1ps

module pe_fu
    import cgra_pkg::*;
(
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    input  logic [op_w-1:0]   op,
    output logic [data_w-1:0] result
);

    logic [data_w-1:0] prod;
    logic [4:0]        shamt;

    assign prod  = a * b;   // low word of the product
    assign shamt = b[4:0];  // shift by low five bits only

    always_comb begin
        case (op)
            op_pass: result = a;
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_mul:  result = prod;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_shl:  result = a << shamt;
            op_shr:  result = a >> shamt;  // logical
            default: result = '0;
        endcase
    end

endmodule

// File: rtl/pe_east_edge.sv
`timescale 1ns/1ps

// east edge element, no din_e or dout_e
module pe_east_edge
    import cgra_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              init,
    input  logic              run,
    input  logic [inst_w-1:0] inst_in,
    input  logic [data_w-1:0] din_n,
    input  logic [data_w-1:0] din_s,
    input  logic [data_w-1:0] din_w,
    output logic [data_w-1:0] dout_n,
    output logic [data_w-1:0] dout_s,
    output logic [data_w-1:0] dout_w
);

    logic [inst_w-1:0]   inst;
    logic [n_regs-1:0]   reg_sel;
    logic                c1;
    logic                c2;
    logic [switch_w-1:0] switch;
    logic [op_w-1:0]     fu_op;

    logic [data_w-1:0] din_0;
    logic [data_w-1:0] din_1;
    logic [data_w-1:0] din_2;
    logic [data_w-1:0] din_3;
    logic [data_w-1:0] r0;
    logic [data_w-1:0] r1;
    logic [data_w-1:0] r2;
    logic [data_w-1:0] r3;
    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] fu_result;
    logic [data_w-1:0] res;

    pe_config_buffer u_cfg (
        .clk     (clk),
        .rst     (rst),
        .init    (init),
        .run     (run),
        .inst_in (inst_in),
        .inst    (inst)
    );

    assign reg_sel = inst[inst_reg_sel_lsb +: n_regs];
    assign c1      = inst[inst_c1_bit];
    assign c2      = inst[inst_c2_bit];
    assign switch  = inst[inst_switch_lsb +: switch_w];
    assign fu_op   = inst[inst_op_lsb +: op_w];

    // c1 swaps north and west, c2 picks which south register gets din_s
    assign din_0 = c1 ? din_n : din_w;
    assign din_1 = c1 ? din_w : din_n;
    assign din_2 = c2 ? din_s : '0;
    assign din_3 = c2 ? '0 : din_s;

    pe_reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .reg_sel (reg_sel),
        .din_0   (din_0),
        .din_1   (din_1),
        .din_2   (din_2),
        .din_3   (din_3),
        .din_res (res),
        .r0      (r0),
        .r1      (r1),
        .r2      (r2),
        .r3      (r3)
    );

    pe_crossbar u_xbar (
        .switch (switch),
        .in0    (din_0),
        .in1    (din_1),
        .r0     (r0),
        .r1     (r1),
        .r2     (r2),
        .r3     (r3),
        .res    (res),
        .op_a   (op_a),
        .op_b   (op_b),
        .dout_n (dout_n),
        .dout_s (dout_s),
        .dout_w (dout_w),
        .dout_e ()  // edge of the fabric
    );

    pe_fu u_fu (
        .a      (op_a),
        .b      (op_b),
        .op     (fu_op),
        .result (fu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res <= fu_result;
        end
    end

endmodule

// File: rtl/cgra_edge_column.sv
`timescale 1ns/1ps

module cgra_edge_column
    import cgra_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              init,
    input  logic              run,
    input  logic [inst_w-1:0] inst_0,
    input  logic [inst_w-1:0] inst_1,
    input  logic [data_w-1:0] din_n,
    input  logic [data_w-1:0] din_s,
    input  logic [data_w-1:0] din_w0,
    input  logic [data_w-1:0] din_w1,
    output logic [data_w-1:0] dout_n,
    output logic [data_w-1:0] dout_s,
    output logic [data_w-1:0] dout_w0,
    output logic [data_w-1:0] dout_w1
);

    logic [data_w-1:0] n_to_s;  // north dout_s into south din_n
    logic [data_w-1:0] s_to_n;  // south dout_n into north din_s, registers only

    pe_east_edge u_pe_north (
        .clk     (clk),
        .rst     (rst),
        .init    (init),
        .run     (run),
        .inst_in (inst_0),
        .din_n   (din_n),
        .din_s   (s_to_n),
        .din_w   (din_w0),
        .dout_n  (dout_n),
        .dout_s  (n_to_s),
        .dout_w  (dout_w0)
    );

    pe_east_edge u_pe_south (
        .clk     (clk),
        .rst     (rst),
        .init    (init),
        .run     (run),
        .inst_in (inst_1),
        .din_n   (n_to_s),
        .din_s   (din_s),
        .din_w   (din_w1),
        .dout_n  (s_to_n),
        .dout_s  (dout_s),
        .dout_w  (dout_w1)
    );

endmodule

// File: dv/cgra_assert.sv
`timescale 1ns/1ps

module cgra_assert
    import cgra_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              init,
    input logic              run,
    input logic [inst_w-1:0] inst
);

    int fail_count = 0;  // read by the testbench at the end

    inst_cleared_by_reset: assert property (@(posedge clk) rst |=> inst == '0)
        else begin
            $error("current instruction not zero after reset");
            fail_count++;
        end

    // init has priority, nothing issues
    inst_held_on_init: assert property (@(posedge clk) disable iff (rst)
        init |=> $stable(inst))
        else begin
            $error("current instruction changed on an init cycle");
            fail_count++;
        end

    inst_held_when_idle: assert property (@(posedge clk) disable iff (rst)
        (!init && !run) |=> $stable(inst))
        else begin
            $error("current instruction changed with init and run low");
            fail_count++;
        end

endmodule

bind pe_config_buffer cgra_assert u_assert (
    .clk  (clk),
    .rst  (rst),
    .init (init),
    .run  (run),
    .inst (inst)
);

// File: dv/tb_cgra.sv
`timescale 1ns/1ps

module tb_cgra
    import cgra_pkg::*;
();

    localparam int half_period = 4;
    localparam int drive_delay = 1;
    localparam int sample_wait = 2 * half_period - 2 * drive_delay;  // 1 ns before next edge
    localparam int reset_cycles = 10;

    logic              clk = 1'b0;
    logic              rst;
    logic              init;
    logic              run;
    logic [inst_w-1:0] inst_0;
    logic [inst_w-1:0] inst_1;
    logic [data_w-1:0] din_n;
    logic [data_w-1:0] din_s;
    logic [data_w-1:0] din_w0;
    logic [data_w-1:0] din_w1;
    logic [data_w-1:0] dout_n;
    logic [data_w-1:0] dout_s;
    logic [data_w-1:0] dout_w0;
    logic [data_w-1:0] dout_w1;

    int cycle_count = 0;
    int cycle_limit = 0;  // armed once the record count is known

    cgra_edge_column UUT (
        .clk     (clk),
        .rst     (rst),
        .init    (init),
        .run     (run),
        .inst_0  (inst_0),
        .inst_1  (inst_1),
        .din_n   (din_n),
        .din_s   (din_s),
        .din_w0  (din_w0),
        .din_w1  (din_w1),
        .dout_n  (dout_n),
        .dout_s  (dout_s),
        .dout_w0 (dout_w0),
        .dout_w1 (dout_w1)
    );

    always #half_period clk = ~clk;

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input logic [8*32-1:0] test_name, input logic [8*8-1:0] port,
                              input logic [data_w-1:0] expected, input logic [data_w-1:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Mismatch in %0s on %0s: expected %h, actual %h",
                                      test_name, port, expected, actual));
        end
    endtask

    // skips blank lines and lines starting with #
    function automatic bit is_data_line(input logic [8*256-1:0] text);
        logic [7:0] c;
        for (int i = 255; i >= 0; i--) begin
            c = text[i*8 +: 8];
            if (c != 8'h00 && c != 8'h20 && c != 8'h09 && c != 8'h0a && c != 8'h0d) begin
                return c != "#";
            end
        end
        return 1'b0;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_on_failure("Run did not finish within its cycle limit");
        end
    end

    initial begin
        int                fd;
        int                n_records;
        int                n_read;
        int                n_fields;
        int                assert_errors;
        logic [8*256-1:0]  line;
        logic [8*16-1:0]   kind;
        logic [8*32-1:0]   name;
        logic [inst_w-1:0] i0;
        logic [inst_w-1:0] i1;
        logic [data_w-1:0] vn;
        logic [data_w-1:0] vs;
        logic [data_w-1:0] vw0;
        logic [data_w-1:0] vw1;
        logic [data_w-1:0] en;
        logic [data_w-1:0] es;
        logic [data_w-1:0] ew0;
        logic [data_w-1:0] ew1;

        rst    = 1'b1;
        init   = 1'b0;
        run    = 1'b0;
        inst_0 = '0;
        inst_1 = '0;
        din_n  = '0;
        din_s  = '0;
        din_w0 = '0;
        din_w1 = '0;

        fd = $fopen("dv/cgra_stimulus.txt", "r");
        if (fd == 0) begin
            stop_on_failure("Could not open the stimulus file dv/cgra_stimulus.txt");
        end
        n_records = -1;
        while (n_records < 0 && !$feof(fd)) begin
            line = '0;
            void'($fgets(line, fd));
            if (is_data_line(line)) begin
                n_fields = $sscanf(line, "%d", n_records);
            end
        end
        if (n_records <= 0) begin
            stop_on_failure("The stimulus file has no record count");
        end
        cycle_limit = reset_cycles + 2 * n_records + 50;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;

        n_read = 0;
        while (!$feof(fd)) begin
            line = '0;
            void'($fgets(line, fd));
            if (is_data_line(line)) begin
                n_fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", kind, name,
                                   i0, i1, vn, vs, vw0, vw1, en, es, ew0, ew1);
                if (n_fields != 12) begin
                    stop_on_failure("A stimulus record does not have twelve fields");
                end
                if (kind != "init" && kind != "run" && kind != "idle" && kind != "both") begin
                    stop_on_failure("A stimulus record has an unknown kind");
                end
                // first cycle carries the control, second holds the data steady
                @(posedge clk);
                #drive_delay;
                inst_0 = i0;
                inst_1 = i1;
                din_n  = vn;
                din_s  = vs;
                din_w0 = vw0;
                din_w1 = vw1;
                init   = (kind == "init" || kind == "both");
                run    = (kind == "run" || kind == "both");
                @(posedge clk);
                #drive_delay;
                init = 1'b0;
                run  = 1'b0;
                #sample_wait;
                if (kind != "init") begin
                    check_data(name, "dout_n", en, dout_n);
                    check_data(name, "dout_s", es, dout_s);
                    check_data(name, "dout_w0", ew0, dout_w0);
                    check_data(name, "dout_w1", ew1, dout_w1);
                end
                n_read++;
            end
        end
        $fclose(fd);
        if (n_read != n_records) begin
            stop_on_failure("Number of records read differs from the count in the file");
        end

        assert_errors = UUT.u_pe_north.u_cfg.u_assert.fail_count
                      + UUT.u_pe_south.u_cfg.u_assert.fail_count;
        if (assert_errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// File: dv/cgra_stimulus.txt
# kind name inst_0 inst_1 din_n din_s din_w0 din_w1 exp_n exp_s exp_w0 exp_w1 (hex)
# kinds: idle, init, run, both; init records ignore the expected columns
36
idle reset_outputs 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot0 004a000 008a010 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot1 004a010 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot2 01ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot3 11ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot4 21ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot5 31ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot6 41ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot7 51ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot8 61ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot9 71ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot10 81ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot11 91ca440 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot12 01ca02f 0051000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot13 011d04c 0051000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot14 00ee000 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
init load_slot15 0011010 0050000 00000024 cafe0001 87654321 00005a5a 00000000 00000000 00000000 00000000
run route_c1_clear 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 87654321 00005a5a
run route_c1_set 0000000 0000000 00000024 cafe0001 87654321 00005a5a 87654321 00000024 00000024 00005a5a
run fu_idle_result 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 00000000 00005a5a
run fu_pass 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 87654321 00005a5a
run fu_add 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 87654345 00005a5a
run fu_sub 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 876542fd 00005a5a
run fu_mul 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 0a3d70a4 00005a5a
run fu_and 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 00000020 00005a5a
run fu_or 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 87654325 00005a5a
run fu_xor 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 87654305 00005a5a
run fu_shl 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 76543210 00005a5a
run fu_shr 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 08765432 00005a5a
run fu_unused_op 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 00000000 00005a5a
run regs_c2_set 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00005a5a 87654321 00000024 00005a5a
run regs_c2_clear 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00005a5a 00000000 87654321 00005a5a
run route_last_slot 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 00000000 00005a5a
both init_over_run 0050000 0050000 00000024 cafe0001 87654321 00005a5a 00000024 87654321 00000000 00005a5a
run wrap_slot0 0000000 0000000 00000024 cafe0001 87654321 00005a5a 00000000 00000024 87654321 00005a5a
run wrap_slot1 0000000 0000000 00000024 cafe0001 87654321 00005a5a 87654321 00000024 00000024 00005a5a

// File: tb.f
rtl/cgra_pkg.sv
rtl/pe_config_buffer.sv
rtl/pe_reg_file.sv
rtl/pe_crossbar.sv
rtl/pe_fu.sv
rtl/pe_east_edge.sv
rtl/cgra_edge_column.sv
dv/cgra_assert.sv
dv/tb_cgra.sv
